// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vga_output_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
+incdir+src
src/vga_mode_pkg.sv
src/vga_pixel_pkg.sv
src/vga_mode_table.sv
src/vga_timing.sv
src/vga_scan_out.sv
src/vga_line_buffer.sv
src/vga_output.sv
tests/vga_output_tb.sv

// ==== src/vga_line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module vga_line_buffer (
   input  logic                     vga_clk,
   input  logic                     we,
   input  vga_pixel_pkg::buf_addr_t waddr,
   input  vga_pixel_pkg::rgb565_t   wdata,
   input  vga_pixel_pkg::buf_addr_t raddr,
   output vga_pixel_pkg::rgb565_t   rdata
);

   // bank 0 sits at 0, bank 1 right after it
   vga_pixel_pkg::rgb565_t mem [0:2*`VGA_BANK_WORDS-1];

   always_ff @(posedge vga_clk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   always_ff @(posedge vga_clk) begin
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

// ==== src/vga_macros.svh ====
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// 640x480, negative syncs
`define VGA_640_H_TOTAL       800
`define VGA_640_H_SYNC_W      96
`define VGA_640_H_DE_START    144
`define VGA_640_H_DE_END      784
`define VGA_640_H_PF_START    176
`define VGA_640_H_PF_END      752
`define VGA_640_H_PF_START_N  240
`define VGA_640_H_PF_END_N    688
`define VGA_640_V_TOTAL       525
`define VGA_640_V_SYNC_W      2
`define VGA_640_V_DE_START    35
`define VGA_640_V_DE_END      515
`define VGA_640_V_PF_START    67
`define VGA_640_V_PF_END      483
`define VGA_640_H_SYNC_POL    0
`define VGA_640_V_SYNC_POL    0
`define VGA_640_SCALE         0

// 800x600
`define VGA_800_H_TOTAL       1056
`define VGA_800_H_SYNC_W      128
`define VGA_800_H_DE_START    216
`define VGA_800_H_DE_END      1016
`define VGA_800_H_PF_START    248
`define VGA_800_H_PF_END      984
`define VGA_800_H_PF_START_N  312
`define VGA_800_H_PF_END_N    920
`define VGA_800_V_TOTAL       628
`define VGA_800_V_SYNC_W      4
`define VGA_800_V_DE_START    27
`define VGA_800_V_DE_END      627
`define VGA_800_V_PF_START    59
`define VGA_800_V_PF_END      595
`define VGA_800_H_SYNC_POL    1
`define VGA_800_V_SYNC_POL    1
`define VGA_800_SCALE         0

// 1920x1080, source pixels doubled
`define VGA_1080_H_TOTAL      2200
`define VGA_1080_H_SYNC_W     44
`define VGA_1080_H_DE_START   192
`define VGA_1080_H_DE_END     2112
`define VGA_1080_H_PF_START   224
`define VGA_1080_H_PF_END     2080
`define VGA_1080_H_PF_START_N 288
`define VGA_1080_H_PF_END_N   2016
`define VGA_1080_V_TOTAL      1125
`define VGA_1080_V_SYNC_W     5
`define VGA_1080_V_DE_START   41
`define VGA_1080_V_DE_END     1121
`define VGA_1080_V_PF_START   73
`define VGA_1080_V_PF_END     1089
`define VGA_1080_H_SYNC_POL   1
`define VGA_1080_V_SYNC_POL   1
`define VGA_1080_SCALE        1

`define VGA_BANK_WORDS        640
`define VGA_PIX_LEAD          4

`endif

// ==== src/vga_mode_pkg.sv ====
`default_nettype none

package vga_mode_pkg;

   typedef enum logic [1:0] {
      mode_640x480,
      mode_800x600,
      mode_1920x1080
   } vga_mode_e;

   typedef logic [11:0] coord_t;

   // one complete timing set, as loaded at frame start
   typedef struct packed {
      coord_t h_total;
      coord_t h_sync_w;
      coord_t h_de_start;
      coord_t h_de_end;
      coord_t h_pf_start;
      coord_t h_pf_end;
      coord_t h_pf_start_narrow;
      coord_t h_pf_end_narrow;
      coord_t v_total;
      coord_t v_sync_w;
      coord_t v_de_start;
      coord_t v_de_end;
      coord_t v_pf_start;
      coord_t v_pf_end;
      logic   h_sync_pol;
      logic   v_sync_pol;
      logic   scale;
   } timing_set_t;

endpackage

`default_nettype wire

// ==== src/vga_mode_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module vga_mode_table (
   input  logic                    vga_clk,
   input  logic                    reset_n,
   input  vga_mode_pkg::vga_mode_e vga_mode_sel,
   input  logic                    frame_tick,
   output vga_mode_pkg::coord_t    h_total,
   output vga_mode_pkg::coord_t    h_sync_w,
   output vga_mode_pkg::coord_t    h_de_start,
   output vga_mode_pkg::coord_t    h_de_end,
   output vga_mode_pkg::coord_t    h_pf_start,
   output vga_mode_pkg::coord_t    h_pf_end,
   output vga_mode_pkg::coord_t    h_pf_start_narrow,
   output vga_mode_pkg::coord_t    h_pf_end_narrow,
   output vga_mode_pkg::coord_t    v_total,
   output vga_mode_pkg::coord_t    v_sync_w,
   output vga_mode_pkg::coord_t    v_de_start,
   output vga_mode_pkg::coord_t    v_de_end,
   output vga_mode_pkg::coord_t    v_pf_start,
   output vga_mode_pkg::coord_t    v_pf_end,
   output logic                    h_sync_pol,
   output logic                    v_sync_pol,
   output logic                    scale,
   output logic                    mode_restart,
   output logic                    mode_changed
);

   vga_mode_pkg::timing_set_t set_q;
   vga_mode_pkg::vga_mode_e   mode_q;

   function automatic vga_mode_pkg::timing_set_t mode_set(input vga_mode_pkg::vga_mode_e m);
      vga_mode_pkg::timing_set_t s;
      case (m)
         vga_mode_pkg::mode_800x600:
            s = '{`VGA_800_H_TOTAL, `VGA_800_H_SYNC_W, `VGA_800_H_DE_START,
                  `VGA_800_H_DE_END, `VGA_800_H_PF_START, `VGA_800_H_PF_END,
                  `VGA_800_H_PF_START_N, `VGA_800_H_PF_END_N,
                  `VGA_800_V_TOTAL, `VGA_800_V_SYNC_W, `VGA_800_V_DE_START,
                  `VGA_800_V_DE_END, `VGA_800_V_PF_START, `VGA_800_V_PF_END,
                  `VGA_800_H_SYNC_POL, `VGA_800_V_SYNC_POL, `VGA_800_SCALE};
         vga_mode_pkg::mode_1920x1080:
            s = '{`VGA_1080_H_TOTAL, `VGA_1080_H_SYNC_W, `VGA_1080_H_DE_START,
                  `VGA_1080_H_DE_END, `VGA_1080_H_PF_START, `VGA_1080_H_PF_END,
                  `VGA_1080_H_PF_START_N, `VGA_1080_H_PF_END_N,
                  `VGA_1080_V_TOTAL, `VGA_1080_V_SYNC_W, `VGA_1080_V_DE_START,
                  `VGA_1080_V_DE_END, `VGA_1080_V_PF_START, `VGA_1080_V_PF_END,
                  `VGA_1080_H_SYNC_POL, `VGA_1080_V_SYNC_POL, `VGA_1080_SCALE};
         default:
            s = '{`VGA_640_H_TOTAL, `VGA_640_H_SYNC_W, `VGA_640_H_DE_START,
                  `VGA_640_H_DE_END, `VGA_640_H_PF_START, `VGA_640_H_PF_END,
                  `VGA_640_H_PF_START_N, `VGA_640_H_PF_END_N,
                  `VGA_640_V_TOTAL, `VGA_640_V_SYNC_W, `VGA_640_V_DE_START,
                  `VGA_640_V_DE_END, `VGA_640_V_PF_START, `VGA_640_V_PF_END,
                  `VGA_640_H_SYNC_POL, `VGA_640_V_SYNC_POL, `VGA_640_SCALE};
      endcase
      return s;
   endfunction

   // a new mode only lands on the frame boundary
   assign mode_restart = frame_tick && (vga_mode_sel != mode_q);

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         set_q        <= mode_set(vga_mode_pkg::mode_640x480);
         mode_q       <= vga_mode_pkg::mode_640x480;
         mode_changed <= 1'b0;
      end else begin
         mode_changed <= mode_restart;
         if (mode_restart) begin
            set_q  <= mode_set(vga_mode_sel);
            mode_q <= vga_mode_sel;
         end
      end
   end

   assign {h_total, h_sync_w, h_de_start, h_de_end, h_pf_start, h_pf_end,
           h_pf_start_narrow, h_pf_end_narrow, v_total, v_sync_w, v_de_start,
           v_de_end, v_pf_start, v_pf_end, h_sync_pol, v_sync_pol, scale} = set_q;

   // restart puts the counters back on line 1 before the next frame tick
   changed_single: assert property (@(posedge vga_clk) disable iff (!reset_n)
      mode_changed |=> !mode_changed);

endmodule

`default_nettype wire

// ==== src/vga_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_output (
   input  logic                     vga_clk,
   input  logic                     reset_n,
   input  vga_mode_pkg::vga_mode_e  vga_mode_sel,
   input  logic                     narrow,
   input  logic                     double_pixel,
   input  logic                     blank_scanline,
   input  vga_pixel_pkg::rgb565_t   border_color,
   input  logic                     buf_we,
   input  vga_pixel_pkg::buf_addr_t buf_waddr,
   input  vga_pixel_pkg::rgb565_t   buf_wdata,
   output logic                     vga_hs,
   output logic                     vga_vs,
   output logic [4:0]               vga_r,
   output logic [5:0]               vga_g,
   output logic [4:0]               vga_b,
   output logic                     h_blank,
   output logic                     v_blank,
   output logic                     frame_start,
   output logic                     render_start,
   output logic                     scanline_start,
   output logic                     mode_changed,
   output logic                     pixel_scale
);

   wire vga_mode_pkg::coord_t h_total, h_sync_w, h_de_start, h_de_end;
   wire vga_mode_pkg::coord_t h_pf_start, h_pf_end, h_pf_start_narrow, h_pf_end_narrow;
   wire vga_mode_pkg::coord_t v_total, v_sync_w, v_de_start, v_de_end;
   wire vga_mode_pkg::coord_t v_pf_start, v_pf_end;
   wire logic h_sync_pol, v_sync_pol, mode_restart, frame_tick;
   wire logic h_de, v_de, h_pf, v_pf, h_pf_pix;
   wire logic line_end, pf_first_line, pf_last_line;
   wire vga_pixel_pkg::buf_addr_t rd_addr;
   wire vga_pixel_pkg::rgb565_t   rd_data;

   vga_mode_table u_mode_table (
      .vga_clk(vga_clk), .reset_n(reset_n), .vga_mode_sel(vga_mode_sel),
      .frame_tick(frame_tick),
      .h_total(h_total), .h_sync_w(h_sync_w), .h_de_start(h_de_start), .h_de_end(h_de_end),
      .h_pf_start(h_pf_start), .h_pf_end(h_pf_end),
      .h_pf_start_narrow(h_pf_start_narrow), .h_pf_end_narrow(h_pf_end_narrow),
      .v_total(v_total), .v_sync_w(v_sync_w), .v_de_start(v_de_start), .v_de_end(v_de_end),
      .v_pf_start(v_pf_start), .v_pf_end(v_pf_end),
      .h_sync_pol(h_sync_pol), .v_sync_pol(v_sync_pol), .scale(pixel_scale),
      .mode_restart(mode_restart), .mode_changed(mode_changed)
   );

   vga_timing u_timing (
      .vga_clk(vga_clk), .reset_n(reset_n),
      .h_total(h_total), .h_sync_w(h_sync_w), .h_de_start(h_de_start), .h_de_end(h_de_end),
      .h_pf_start(h_pf_start), .h_pf_end(h_pf_end),
      .h_pf_start_narrow(h_pf_start_narrow), .h_pf_end_narrow(h_pf_end_narrow),
      .v_total(v_total), .v_sync_w(v_sync_w), .v_de_start(v_de_start), .v_de_end(v_de_end),
      .v_pf_start(v_pf_start), .v_pf_end(v_pf_end),
      .h_sync_pol(h_sync_pol), .v_sync_pol(v_sync_pol),
      .mode_restart(mode_restart), .narrow(narrow),
      .vga_hs(vga_hs), .vga_vs(vga_vs), .h_de(h_de), .v_de(v_de),
      .h_pf(h_pf), .v_pf(v_pf), .h_pf_pix(h_pf_pix), .line_end(line_end),
      .pf_first_line(pf_first_line), .pf_last_line(pf_last_line),
      .frame_tick(frame_tick), .frame_start(frame_start),
      .render_start(render_start), .scanline_start(scanline_start)
   );

   vga_scan_out u_scan_out (
      .vga_clk(vga_clk), .reset_n(reset_n), .scale(pixel_scale),
      .double_pixel(double_pixel), .blank_scanline(blank_scanline),
      .border_color(border_color),
      .h_de(h_de), .v_de(v_de), .h_pf(h_pf), .v_pf(v_pf), .h_pf_pix(h_pf_pix),
      .line_end(line_end), .pf_first_line(pf_first_line), .pf_last_line(pf_last_line),
      .mode_restart(mode_restart), .rd_data(rd_data), .rd_addr(rd_addr),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
      .h_blank(h_blank), .v_blank(v_blank)
   );

   vga_line_buffer u_line_buffer (
      .vga_clk(vga_clk), .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
      .raddr(rd_addr), .rdata(rd_data)
   );

endmodule

`default_nettype wire

// ==== src/vga_pixel_pkg.sv ====
`default_nettype none

package vga_pixel_pkg;

   // which repeat of the source line is on screen
   typedef enum logic [3:0] {
      line_0    = 4'd0,
      line_1,
      line_2,
      line_3,
      line_4,
      line_5,
      line_6,
      line_7,
      line_idle = 4'hf
   } bank_state_e;

   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

   typedef logic [10:0] buf_addr_t;

endpackage

`default_nettype wire

// ==== src/vga_scan_out.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module vga_scan_out (
   input  logic                     vga_clk,
   input  logic                     reset_n,
   input  logic                     scale,
   input  logic                     double_pixel,
   input  logic                     blank_scanline,
   input  vga_pixel_pkg::rgb565_t   border_color,
   input  logic                     h_de,
   input  logic                     v_de,
   input  logic                     h_pf,
   input  logic                     v_pf,
   input  logic                     h_pf_pix,
   input  logic                     line_end,
   input  logic                     pf_first_line,
   input  logic                     pf_last_line,
   input  logic                     mode_restart,
   input  vga_pixel_pkg::rgb565_t   rd_data,
   output vga_pixel_pkg::buf_addr_t rd_addr,
   output logic [4:0]               vga_r,
   output logic [5:0]               vga_g,
   output logic [4:0]               vga_b,
   output logic                     h_blank,
   output logic                     v_blank
);

   vga_pixel_pkg::bank_state_e line_state;
   vga_pixel_pkg::rgb565_t     pix;
   logic [2:0]                 step;
   logic                       bank_sel;
   logic                       double_q;
   logic                       show_line;
   logic [1:0]                 rep_max;
   logic [1:0]                 rep_cnt;
   logic [1:0]                 lead_cnt;
   logic [9:0]                 offset;

   assign step     = line_state[2:0] + 3'd1;
   // bank flips every two lines, every four when scaled
   assign bank_sel = scale ? line_state[2] : line_state[1];

   always_ff @(posedge vga_clk) begin
      if (!reset_n || mode_restart) begin
         line_state <= vga_pixel_pkg::line_idle;
         double_q   <= 1'b0;
         show_line  <= 1'b0;
      end else if (line_end) begin
         double_q  <= double_pixel;
         show_line <= !blank_scanline;
         if (pf_last_line)
            line_state <= vga_pixel_pkg::line_idle;
         else if (pf_first_line)
            line_state <= vga_pixel_pkg::line_0;
         else if (line_state != vga_pixel_pkg::line_idle)
            line_state <= vga_pixel_pkg::bank_state_e'({1'b0, scale & step[2], step[1:0]});
      end
   end

   // repeat count minus one: 0, 1 or 3
   assign rep_max = {double_q & scale, double_q | scale};

   // hold offset 0 through the lead, then step once per repeat
   always_ff @(posedge vga_clk) begin
      if (!reset_n || !(h_pf_pix && v_pf)) begin
         offset   <= '0;
         rep_cnt  <= '0;
         lead_cnt <= '0;
      end else if (lead_cnt != 2'(`VGA_PIX_LEAD - 1)) begin
         lead_cnt <= lead_cnt + 2'd1;
      end else if (rep_cnt != rep_max) begin
         rep_cnt <= rep_cnt + 2'd1;
      end else begin
         rep_cnt <= '0;
         if (offset != 10'(`VGA_BANK_WORDS - 1))
            offset <= offset + 10'd1;
      end
   end

   assign rd_addr = vga_pixel_pkg::buf_addr_t'(offset)
                  + (bank_sel ? 11'(`VGA_BANK_WORDS) : 11'd0);

   always_comb begin
      if (!(h_de && v_de))
         pix = '0;
      else if (h_pf && v_pf && show_line)
         pix = rd_data;
      else
         pix = border_color;
   end

   assign vga_r   = pix.r;
   assign vga_g   = pix.g;
   assign vga_b   = pix.b;
   assign h_blank = !h_de;
   assign v_blank = !v_de;

   // playfield opens only once the read lead has run out
   lead_done_in_pf: assert property (@(posedge vga_clk) disable iff (!reset_n)
      (h_pf && v_pf) |-> (lead_cnt == 2'(`VGA_PIX_LEAD - 1)));

endmodule

`default_nettype wire

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module vga_timing (
   input  logic                 vga_clk,
   input  logic                 reset_n,
   input  vga_mode_pkg::coord_t h_total,
   input  vga_mode_pkg::coord_t h_sync_w,
   input  vga_mode_pkg::coord_t h_de_start,
   input  vga_mode_pkg::coord_t h_de_end,
   input  vga_mode_pkg::coord_t h_pf_start,
   input  vga_mode_pkg::coord_t h_pf_end,
   input  vga_mode_pkg::coord_t h_pf_start_narrow,
   input  vga_mode_pkg::coord_t h_pf_end_narrow,
   input  vga_mode_pkg::coord_t v_total,
   input  vga_mode_pkg::coord_t v_sync_w,
   input  vga_mode_pkg::coord_t v_de_start,
   input  vga_mode_pkg::coord_t v_de_end,
   input  vga_mode_pkg::coord_t v_pf_start,
   input  vga_mode_pkg::coord_t v_pf_end,
   input  logic                 h_sync_pol,
   input  logic                 v_sync_pol,
   input  logic                 mode_restart,
   input  logic                 narrow,
   output logic                 vga_hs,
   output logic                 vga_vs,
   output logic                 h_de,
   output logic                 v_de,
   output logic                 h_pf,
   output logic                 v_pf,
   output logic                 h_pf_pix,
   output logic                 line_end,
   output logic                 pf_first_line,
   output logic                 pf_last_line,
   output logic                 frame_tick,
   output logic                 frame_start,
   output logic                 render_start,
   output logic                 scanline_start
);

   vga_mode_pkg::coord_t x_cnt;
   vga_mode_pkg::coord_t y_cnt;
   vga_mode_pkg::coord_t pf_start_sel;
   vga_mode_pkg::coord_t pf_end_sel;
   logic                 hsync_r;
   logic                 vsync_r;
   logic                 narrow_q;

   assign pf_start_sel = narrow_q ? h_pf_start_narrow : h_pf_start;
   assign pf_end_sel   = narrow_q ? h_pf_end_narrow : h_pf_end;

   // both counters run from 1 to their total
   always_ff @(posedge vga_clk) begin
      if (!reset_n || mode_restart) begin
         x_cnt <= 12'd1;
         y_cnt <= 12'd1;
      end else if (line_end) begin
         x_cnt <= 12'd1;
         y_cnt <= (y_cnt == v_total) ? 12'd1 : y_cnt + 12'd1;
      end else begin
         x_cnt <= x_cnt + 12'd1;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         line_end       <= 1'b0;
         frame_tick     <= 1'b0;
         frame_start    <= 1'b0;
         render_start   <= 1'b0;
         scanline_start <= 1'b0;
      end else begin
         line_end       <= (x_cnt == h_total - 12'd1);
         frame_tick     <= (x_cnt == 12'd1) && (y_cnt == 12'd1);
         frame_start    <= frame_tick;
         // renderer gets a head start two lines before the playfield
         render_start   <= line_end && (y_cnt == v_pf_start - 12'd2);
         scanline_start <= line_end && (y_cnt != v_pf_start - 12'd2);
      end
   end

   always_ff @(posedge vga_clk) begin
      pf_first_line <= (y_cnt == v_pf_start - 12'd1);
      pf_last_line  <= (y_cnt == v_pf_end);
      if (x_cnt == 12'd1)
         narrow_q <= narrow;
   end

   // sync and window flags, set at one column and cleared at another
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         hsync_r  <= 1'b1;
         vsync_r  <= 1'b1;
         h_de     <= 1'b0;
         v_de     <= 1'b0;
         h_pf     <= 1'b0;
         v_pf     <= 1'b0;
         h_pf_pix <= 1'b0;
      end else begin
         if (x_cnt == 12'd1)
            hsync_r <= 1'b0;
         else if (x_cnt == h_sync_w)
            hsync_r <= 1'b1;
         if (y_cnt == 12'd1)
            vsync_r <= 1'b0;
         else if (y_cnt == v_sync_w)
            vsync_r <= 1'b1;
         if (x_cnt == h_de_start)
            h_de <= 1'b1;
         else if (x_cnt == h_de_end)
            h_de <= 1'b0;
         if (y_cnt == v_de_start)
            v_de <= 1'b1;
         else if (y_cnt == v_de_end)
            v_de <= 1'b0;
         if (x_cnt == pf_start_sel)
            h_pf <= 1'b1;
         else if (x_cnt == pf_end_sel)
            h_pf <= 1'b0;
         if (y_cnt == v_pf_start)
            v_pf <= 1'b1;
         else if (y_cnt == v_pf_end)
            v_pf <= 1'b0;
         // opens early to prime the read pipeline, closes with h_pf
         if (x_cnt == pf_start_sel - 12'(`VGA_PIX_LEAD))
            h_pf_pix <= 1'b1;
         else if (x_cnt == pf_end_sel)
            h_pf_pix <= 1'b0;
      end
   end

   assign vga_hs = hsync_r ^ h_sync_pol;
   assign vga_vs = vsync_r ^ v_sync_pol;

   x_in_range: assert property (@(posedge vga_clk) disable iff (!reset_n)
      x_cnt <= h_total);

endmodule

`default_nettype wire

// ==== tests/vga_output_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_output_tb;

   typedef enum int {
      probe_hs,
      probe_vs,
      probe_h_blank,
      probe_frame_start,
      probe_render_start,
      probe_mode_changed
   } probe_e;

   // longest frame is 2200 x 1125 clocks
   localparam int          frame_limit = 3000000;
   localparam int          line_limit  = 4096;
   localparam int          bank_words  = 640;
   localparam logic [15:0] border      = 16'h0421;
   localparam logic [15:0] fill_base   = 16'h8000;

   logic                     vga_clk;
   logic                     reset_n;
   vga_mode_pkg::vga_mode_e  vga_mode_sel;
   logic                     narrow;
   logic                     double_pixel;
   logic                     blank_scanline;
   vga_pixel_pkg::rgb565_t   border_color;
   logic                     buf_we;
   vga_pixel_pkg::buf_addr_t buf_waddr;
   vga_pixel_pkg::rgb565_t   buf_wdata;
   logic                     vga_hs;
   logic                     vga_vs;
   logic [4:0]               vga_r;
   logic [5:0]               vga_g;
   logic [4:0]               vga_b;
   logic                     h_blank;
   logic                     v_blank;
   logic                     frame_start;
   logic                     render_start;
   logic                     scanline_start;
   logic                     mode_changed;
   logic                     pixel_scale;

   int          errors;
   int          tests_run;
   int          tests_failed;
   bit          hung;
   logic [15:0] line_q[$];

   vga_output dut (.*);

   initial begin
      vga_clk = 1'b0;
      forever #20 vga_clk = ~vga_clk;
   end

   function automatic logic probe(input probe_e sel);
      case (sel)
         probe_hs:           return vga_hs;
         probe_vs:           return vga_vs;
         probe_h_blank:      return h_blank;
         probe_frame_start:  return frame_start;
         probe_render_start: return render_start;
         default:            return mode_changed;
      endcase
   endfunction

   function automatic logic [15:0] colour();
      return {vga_r, vga_g, vga_b};
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
         errors++;
      end
   endtask

   task automatic note_timeout(input string what, input int limit);
      $display("timeout: %s did not happen within %0d clocks", what, limit);
      errors++;
      hung = 1'b1;
   endtask

   // samples once per clock, on the falling edge
   task automatic wait_level(input probe_e sel, input logic level, input int limit,
                             input string what, output int cycles);
      cycles = 0;
      if (hung)
         return;
      while (probe(sel) !== level) begin
         if (cycles >= limit) begin
            note_timeout(what, limit);
            return;
         end
         @(negedge vga_clk);
         cycles++;
      end
   endtask

   task automatic next_pulse(input probe_e sel, input int limit, input string what);
      int spent;
      wait_level(sel, 1'b0, limit, what, spent);
      wait_level(sel, 1'b1, limit, what, spent);
   endtask

   // low time and full period, starting at a falling edge
   task automatic measure_period(input probe_e sel, input int limit, input string what,
                                 output int low_time, output int period);
      int spent;
      int high_time;
      wait_level(sel, 1'b1, limit, what, spent);
      wait_level(sel, 1'b0, limit, what, spent);
      wait_level(sel, 1'b1, limit, what, low_time);
      wait_level(sel, 1'b0, limit, what, high_time);
      period = low_time + high_time;
   endtask

   task automatic fill_buffer();
      int a;
      for (a = 0; a < 2 * bank_words; a++) begin
         @(negedge vga_clk);
         buf_we    = 1'b1;
         buf_waddr = vga_pixel_pkg::buf_addr_t'(a);
         buf_wdata = fill_base + 16'(a);
      end
      @(negedge vga_clk);
      buf_we = 1'b0;
   endtask

   // blanking must be black, then the display run goes into line_q
   task automatic capture_line(output int bad_blank);
      int n;
      line_q.delete();
      bad_blank = 0;
      wait_level(probe_h_blank, 1'b1, line_limit, "horizontal blank", n);
      if (hung)
         return;
      n = 0;
      while (h_blank === 1'b1) begin
         if (colour() !== 16'h0000)
            bad_blank++;
         if (n >= line_limit) begin
            note_timeout("display start", line_limit);
            return;
         end
         @(negedge vga_clk);
         n++;
      end
      n = 0;
      while (h_blank === 1'b0) begin
         line_q.push_back(colour());
         if (n >= line_limit) begin
            note_timeout("display end", line_limit);
            return;
         end
         @(negedge vga_clk);
         n++;
      end
   endtask

   task automatic inspect_line(input string tag, input int exp_len, input int exp_start,
                               input int exp_run, input int rep, input logic [15:0] base);
      int          start;
      int          last;
      int          run;
      int          i;
      logic [15:0] want;
      start = -1;
      last  = -1;
      run   = 0;
      compare({tag, " display length"}, line_q.size(), exp_len);
      foreach (line_q[k]) begin
         if (line_q[k] !== border) begin
            if (start < 0)
               start = k;
            last = k;
            run++;
         end
      end
      compare({tag, " playfield start"}, start, exp_start);
      compare({tag, " playfield length"}, run, exp_run);
      // a single unbroken run
      compare({tag, " playfield end"}, last,
              (exp_run > 0) ? exp_start + exp_run - 1 : -1);
      for (i = 0; i < run && start >= 0; i++) begin
         if (i / rep < bank_words) begin
            want = base + 16'(i / rep);
            if (line_q[start + i] !== want) begin
               compare({tag, " pixel"}, 32'(line_q[start + i]), 32'(want));
               break;
            end
         end
      end
   endtask

   task automatic end_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic reset_and_640_timing();
      int e0;
      int low_time;
      int period;
      e0 = errors;
      // still in reset, negative syncs idle high
      compare("vga_hs", 32'(vga_hs), 32'd1);
      compare("vga_vs", 32'(vga_vs), 32'd1);
      compare("colour", 32'(colour()), 32'd0);
      compare("strobes", 32'({frame_start, render_start, scanline_start, mode_changed}), 32'd0);
      compare("pixel_scale", 32'(pixel_scale), 32'd0);
      reset_n = 1'b1;
      measure_period(probe_hs, line_limit, "hs edge", low_time, period);
      compare("hs active clocks", low_time, 96 - 1);
      compare("hs period", period, 800);
      measure_period(probe_vs, frame_limit, "vs edge", low_time, period);
      compare("vs period lines", period / 800, 525);
      compare("vs period remainder", period % 800, 0);
      end_test("reset and 640x480 timing", e0);
   endtask

   task automatic frame_strobes();
      int e0;
      int i;
      int n_frame;
      int n_render;
      int n_scan;
      e0       = errors;
      n_frame  = 0;
      n_render = 0;
      n_scan   = 0;
      next_pulse(probe_frame_start, frame_limit, "frame_start");
      for (i = 0; i < 800 * 525; i++) begin
         @(negedge vga_clk);
         if (frame_start)
            n_frame++;
         if (render_start)
            n_render++;
         if (scanline_start)
            n_scan++;
      end
      compare("frame_start count", n_frame, 1);
      compare("render_start count", n_render, 1);
      compare("scanline_start count", n_scan, 525 - 1);
      end_test("renderer strobes", e0);
   endtask

   task automatic border_and_blanking();
      int e0;
      int i;
      int bad;
      e0  = errors;
      bad = 0;
      next_pulse(probe_frame_start, frame_limit, "frame_start");
      // top of frame is vertical blank
      for (i = 0; i < 800; i++) begin
         @(negedge vga_clk);
         if (!v_blank || colour() !== 16'h0000)
            bad++;
      end
      compare("v_blank cycles not black", bad, 0);
      next_pulse(probe_render_start, frame_limit, "render_start");
      capture_line(bad);
      compare("colour in h_blank", bad, 0);
      inspect_line("border line", 640, -1, 0, 1, fill_base);
      end_test("border and blanking", e0);
   endtask

   task automatic pixel_repetition();
      int e0;
      int bad;
      e0 = errors;
      double_pixel = 1'b0;
      next_pulse(probe_render_start, frame_limit, "render_start");
      capture_line(bad);
      capture_line(bad);
      compare("colour in h_blank", bad, 0);
      inspect_line("single", 640, 32, 576, 1, fill_base);
      double_pixel = 1'b1;
      capture_line(bad);
      inspect_line("double", 640, 32, 576, 2, fill_base);
      // playfield lines 2 and 3 read bank 1
      capture_line(bad);
      inspect_line("double bank 1", 640, 32, 576, 2, fill_base + 16'(bank_words));
      double_pixel = 1'b0;
      end_test("pixel repetition", e0);
   endtask

   task automatic narrow_and_blank_line();
      int e0;
      int bad;
      e0 = errors;
      narrow = 1'b1;
      next_pulse(probe_render_start, frame_limit, "render_start");
      capture_line(bad);
      capture_line(bad);
      inspect_line("narrow", 640, 96, 576 - 128, 1, fill_base);
      blank_scanline = 1'b1;
      capture_line(bad);
      inspect_line("blanked", 640, -1, 0, 1, fill_base);
      blank_scanline = 1'b0;
      narrow         = 1'b0;
      end_test("narrow and blank_scanline", e0);
   endtask

   task automatic mode_switch();
      int e0;
      int i;
      int extra;
      int bad;
      int low_time;
      int period;
      e0    = errors;
      extra = 0;
      vga_mode_sel = vga_mode_pkg::mode_800x600;
      next_pulse(probe_mode_changed, frame_limit, "mode_changed");
      for (i = 0; i < 1056 * 628; i++) begin
         @(negedge vga_clk);
         if (mode_changed)
            extra++;
      end
      compare("extra mode_changed pulses", extra, 0);
      measure_period(probe_hs, line_limit, "hs edge", low_time, period);
      compare("hs period 800x600", period, 1056);
      compare("pixel_scale", 32'(pixel_scale), 32'd0);
      vga_mode_sel = vga_mode_pkg::mode_1920x1080;
      next_pulse(probe_mode_changed, frame_limit, "mode_changed");
      measure_period(probe_hs, line_limit, "hs edge", low_time, period);
      compare("hs period 1920x1080", period, 2200);
      compare("pixel_scale", 32'(pixel_scale), 32'd1);
      next_pulse(probe_render_start, frame_limit, "render_start");
      capture_line(bad);
      inspect_line("1080 border", 1920, -1, 0, 2, fill_base);
      capture_line(bad);
      compare("colour in h_blank", bad, 0);
      inspect_line("1080 scaled", 1920, 32, 1920 - 64, 2, fill_base);
      end_test("mode change", e0);
   endtask

   initial begin
      reset_n        = 1'b0;
      vga_mode_sel   = vga_mode_pkg::mode_640x480;
      narrow         = 1'b0;
      double_pixel   = 1'b0;
      blank_scanline = 1'b0;
      border_color   = border;
      buf_we         = 1'b0;
      buf_waddr      = '0;
      buf_wdata      = '0;
      errors         = 0;
      tests_run      = 0;
      tests_failed   = 0;
      hung           = 1'b0;
      repeat (16) @(negedge vga_clk);
      reset_and_640_timing();
      fill_buffer();
      frame_strobes();
      border_and_blanking();
      pixel_repetition();
      narrow_and_blank_line();
      mode_switch();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire
